// File: rtl/lsu_pkg.sv
// lsu_pkg: shared widths, lane types, operation codes and decode helpers for the load/store unit
`default_nettype none

package lsu_pkg;

    localparam int num_lanes     = 4;
    localparam int word_bytes    = 4;
    localparam int align_bits    = 2;
    localparam int lsuq_size     = 4;
    localparam int lsuq_ptr_bits = $clog2(lsuq_size);

    typedef logic [8*word_bytes-1:0]              word_t;
    typedef word_t [num_lanes-1:0]                lane_data_t;
    typedef logic [num_lanes-1:0]                 lane_mask_t;
    typedef logic [8*word_bytes-align_bits-1:0]   word_addr_t;
    typedef word_addr_t [num_lanes-1:0]           lane_addr_t;
    typedef logic [num_lanes-1:0][word_bytes-1:0] lane_byteen_t;
    typedef logic [num_lanes-1:0][align_bits-1:0] lane_align_t;
    typedef logic [2:0]                           wid_t;
    typedef logic [4:0]                           reg_idx_t;

    // bit 3 marks stores, bit 2 unsigned loads, bits 1:0 the access size
    typedef enum logic [3:0] {
        op_lb    = 4'b0000,
        op_lh    = 4'b0001,
        op_lw    = 4'b0010,
        op_lbu   = 4'b0100,
        op_lhu   = 4'b0101,
        op_sb    = 4'b1000,
        op_sh    = 4'b1001,
        op_sw    = 4'b1010,
        op_fence = 4'b1111
    } lsu_op_t;

    function automatic logic op_is_load(lsu_op_t op);
        return (op == op_lb) || (op == op_lh) || (op == op_lw)
            || (op == op_lbu) || (op == op_lhu);
    endfunction

    function automatic logic op_is_store(lsu_op_t op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw);
    endfunction

    // log2 of access width in bytes
    function automatic logic [1:0] op_size(lsu_op_t op);
        return op[1:0];
    endfunction

endpackage

`default_nettype wire

// File: rtl/lsu_req_format.sv
// lsu_req_format: per-lane address generation, byte enables and store data alignment
`timescale 1ns/1ps
`default_nettype none

module lsu_req_format
    import lsu_pkg::*;
(
    input  lsu_op_t      op,
    input  lane_mask_t   tmask,
    input  lane_data_t   rs1,
    input  lane_data_t   rs2,
    input  word_t        imm,
    input  logic         check,
    output lane_addr_t   addr,
    output lane_byteen_t byteen,
    output lane_data_t   data,
    output lane_align_t  align
);

    logic [1:0] size;

    assign size = op_size(op);

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        word_t                 full_addr;
        logic [align_bits-1:0] lsb_mask;

        assign full_addr = rs1[i] + imm;
        assign addr[i]   = full_addr[8*word_bytes-1:align_bits];
        assign align[i]  = full_addr[align_bits-1:0];

        // store data moves up to its byte lane inside the word
        assign data[i] = rs2[i] << {align[i], 3'b000};

        always_comb begin
            case (size)
                2'd0: begin
                    byteen[i] = word_bytes'(1) << align[i];
                end
                2'd1: begin
                    byteen[i] = word_bytes'(3) << {align[i][1], 1'b0};
                end
                default: begin
                    byteen[i] = '1;
                end
            endcase
        end

        // low offset bits that must be zero for the access size
        assign lsb_mask = {size[1], size[1] | size[0]};

        misalign_a: assert #0 (!(check && tmask[i]) || ((align[i] & lsb_mask) == '0))
            else $error("misaligned access on lane %0d, addr=0x%08h, size=%0d",
                        i, full_addr, size);
    end

endmodule

`default_nettype wire

// File: rtl/lsu_pending_queue.sv
// lsu_pending_queue: in-order FIFO holding metadata of loads waiting for their response
`timescale 1ns/1ps
`default_nettype none

module lsu_pending_queue
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        push,
    input  lsu_op_t     push_op,
    input  wid_t        push_wid,
    input  lane_mask_t  push_tmask,
    input  reg_idx_t    push_rd,
    input  lane_align_t push_align,
    input  logic        pop,
    output lsu_op_t     head_op,
    output wid_t        head_wid,
    output lane_mask_t  head_tmask,
    output reg_idx_t    head_rd,
    output lane_align_t head_align,
    output logic        full,
    output logic        empty
);

    lsu_op_t     op_q    [lsuq_size];
    wid_t        wid_q   [lsuq_size];
    lane_mask_t  tmask_q [lsuq_size];
    reg_idx_t    rd_q    [lsuq_size];
    lane_align_t align_q [lsuq_size];

    logic [lsuq_ptr_bits-1:0] wr_ptr;
    logic [lsuq_ptr_bits-1:0] rd_ptr;
    logic [lsuq_ptr_bits:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[wr_ptr]    <= push_op;
            wid_q[wr_ptr]   <= push_wid;
            tmask_q[wr_ptr] <= push_tmask;
            rd_q[wr_ptr]    <= push_rd;
            align_q[wr_ptr] <= push_align;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + lsuq_ptr_bits'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + lsuq_ptr_bits'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + (lsuq_ptr_bits + 1)'(1);
                2'b01:   count <= count - (lsuq_ptr_bits + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    assign head_op    = op_q[rd_ptr];
    assign head_wid   = wid_q[rd_ptr];
    assign head_tmask = tmask_q[rd_ptr];
    assign head_rd    = rd_q[rd_ptr];
    assign head_align = align_q[rd_ptr];

    assign full  = (count == (lsuq_ptr_bits + 1)'(lsuq_size));
    assign empty = (count == '0);

    // the top must stall loads on full and never see a response with nothing pending
    push_full_a: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("load pushed into full pending queue");

    pop_empty_a: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("response with no load pending");

endmodule

`default_nettype wire

// File: rtl/lsu_load_format.sv
// lsu_load_format: per-lane byte/half selection and sign or zero extension of load data
`timescale 1ns/1ps
`default_nettype none

module lsu_load_format
    import lsu_pkg::*;
(
    input  lsu_op_t     op,
    input  lane_mask_t  tmask,
    input  lane_align_t align,
    input  lane_data_t  rsp_data,
    output lane_data_t  data
);

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        logic [15:0] half;
        logic [7:0]  byte_sel;

        assign half     = align[i][1] ? rsp_data[i][31:16] : rsp_data[i][15:0];
        assign byte_sel = align[i][0] ? half[15:8] : half[7:0];

        always_comb begin
            if (!tmask[i]) begin
                data[i] = '0;
            end else begin
                case (op)
                    op_lb: begin
                        data[i] = {{24{byte_sel[7]}}, byte_sel};
                    end
                    op_lh: begin
                        data[i] = {{16{half[15]}}, half};
                    end
                    op_lbu: begin
                        data[i] = {24'h0, byte_sel};
                    end
                    op_lhu: begin
                        data[i] = {16'h0, half};
                    end
                    default: begin
                        // full word
                        data[i] = rsp_data[i];
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_commit_arb.sv
// lsu_commit_arb: load and store holding slots with load-first selection onto the commit port
`timescale 1ns/1ps
`default_nettype none

module lsu_commit_arb
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ld_valid,
    input  wid_t       ld_wid,
    input  lane_mask_t ld_tmask,
    input  reg_idx_t   ld_rd,
    input  lane_data_t ld_data,
    input  logic       st_valid,
    input  wid_t       st_wid,
    input  lane_mask_t st_tmask,
    input  logic       commit_ready,
    output logic       ld_ready,
    output logic       st_ready,
    output logic       commit_valid,
    output wid_t       commit_wid,
    output lane_mask_t commit_tmask,
    output reg_idx_t   commit_rd,
    output logic       commit_wb,
    output lane_data_t commit_data
);

    logic       ld_full;
    wid_t       ld_q_wid;
    lane_mask_t ld_q_tmask;
    reg_idx_t   ld_q_rd;
    lane_data_t ld_q_data;

    logic       st_full;
    wid_t       st_q_wid;
    lane_mask_t st_q_tmask;

    logic sel_ld;
    logic hold_st;
    logic ld_pop;
    logic st_pop;

    // a store already on offer keeps the port until it is taken
    assign sel_ld = ld_full && !hold_st;
    assign ld_pop = sel_ld && commit_ready;
    assign st_pop = st_full && !sel_ld && commit_ready;

    assign ld_ready = !ld_full || ld_pop;
    assign st_ready = !st_full || st_pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            ld_full <= 1'b0;
            st_full <= 1'b0;
            hold_st <= 1'b0;
        end else begin
            if (ld_valid && ld_ready) begin
                ld_full <= 1'b1;
            end else if (ld_pop) begin
                ld_full <= 1'b0;
            end
            if (st_valid && st_ready) begin
                st_full <= 1'b1;
            end else if (st_pop) begin
                st_full <= 1'b0;
            end
            hold_st <= st_full && !sel_ld && !commit_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid && ld_ready) begin
            ld_q_wid   <= ld_wid;
            ld_q_tmask <= ld_tmask;
            ld_q_rd    <= ld_rd;
            ld_q_data  <= ld_data;
        end
        if (st_valid && st_ready) begin
            st_q_wid   <= st_wid;
            st_q_tmask <= st_tmask;
        end
    end

    assign commit_valid = ld_full || st_full;
    assign commit_wid   = sel_ld ? ld_q_wid : st_q_wid;
    assign commit_tmask = sel_ld ? ld_q_tmask : st_q_tmask;
    // stores and fences write nothing back
    assign commit_rd    = sel_ld ? ld_q_rd : '0;
    assign commit_wb    = sel_ld;
    assign commit_data  = sel_ld ? ld_q_data : '0;

    commit_hold_a: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid
            && $stable({commit_wid, commit_tmask, commit_rd, commit_wb, commit_data}))
        else $error("commit fields changed while stalled");

endmodule

`default_nettype wire

// File: rtl/lsu_unit.sv
// lsu_unit: SIMD load/store unit issuing masked memory requests and committing results in order
`timescale 1ns/1ps
`default_nettype none

module lsu_unit
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         exec_valid,
    input  lsu_op_t      exec_op,
    input  wid_t         exec_wid,
    input  lane_mask_t   exec_tmask,
    input  reg_idx_t     exec_rd,
    input  lane_data_t   exec_rs1,
    input  lane_data_t   exec_rs2,
    input  word_t        exec_imm,
    output logic         exec_ready,

    output logic         mem_req_valid,
    output logic         mem_req_rw,
    output lane_mask_t   mem_req_mask,
    output lane_addr_t   mem_req_addr,
    output lane_byteen_t mem_req_byteen,
    output lane_data_t   mem_req_data,
    input  logic         mem_req_ready,

    input  logic         mem_rsp_valid,
    input  lane_data_t   mem_rsp_data,
    output logic         mem_rsp_ready,

    output logic         commit_valid,
    output wid_t         commit_wid,
    output lane_mask_t   commit_tmask,
    output reg_idx_t     commit_rd,
    output logic         commit_wb,
    output lane_data_t   commit_data,
    input  logic         commit_ready
);

    logic        is_load;
    logic        is_store;
    logic        is_fence;
    logic        exec_fire;
    logic        rsp_fire;
    logic        q_full;
    logic        q_empty;
    logic        st_ready;
    lane_align_t req_align;

    lsu_op_t     head_op;
    wid_t        head_wid;
    lane_mask_t  head_tmask;
    reg_idx_t    head_rd;
    lane_align_t head_align;
    lane_data_t  ld_data;

    assign is_load  = op_is_load(exec_op);
    assign is_store = op_is_store(exec_op);
    assign is_fence = (exec_op == op_fence);

    // fence waits for every outstanding load; undefined codes are dropped
    always_comb begin
        if (is_load) begin
            exec_ready = mem_req_ready && !q_full;
        end else if (is_store) begin
            exec_ready = mem_req_ready && st_ready;
        end else if (is_fence) begin
            exec_ready = q_empty && st_ready;
        end else begin
            exec_ready = 1'b1;
        end
    end

    assign exec_fire = exec_valid && exec_ready;
    assign rsp_fire  = mem_rsp_valid && mem_rsp_ready;

    assign mem_req_valid = exec_valid && ((is_load && !q_full) || (is_store && st_ready));
    assign mem_req_rw    = is_store;
    assign mem_req_mask  = exec_tmask;

    lsu_req_format req_format_i (
        .op     (exec_op),
        .tmask  (exec_tmask),
        .rs1    (exec_rs1),
        .rs2    (exec_rs2),
        .imm    (exec_imm),
        .check  (exec_fire && (is_load || is_store)),
        .addr   (mem_req_addr),
        .byteen (mem_req_byteen),
        .data   (mem_req_data),
        .align  (req_align)
    );

    lsu_pending_queue pending_queue_i (
        .clk        (clk),
        .reset      (reset),
        .push       (exec_fire && is_load),
        .push_op    (exec_op),
        .push_wid   (exec_wid),
        .push_tmask (exec_tmask),
        .push_rd    (exec_rd),
        .push_align (req_align),
        .pop        (rsp_fire),
        .head_op    (head_op),
        .head_wid   (head_wid),
        .head_tmask (head_tmask),
        .head_rd    (head_rd),
        .head_align (head_align),
        .full       (q_full),
        .empty      (q_empty)
    );

    lsu_load_format load_format_i (
        .op       (head_op),
        .tmask    (head_tmask),
        .align    (head_align),
        .rsp_data (mem_rsp_data),
        .data     (ld_data)
    );

    // response acceptance follows the load slot
    lsu_commit_arb commit_arb_i (
        .clk          (clk),
        .reset        (reset),
        .ld_valid     (mem_rsp_valid),
        .ld_wid       (head_wid),
        .ld_tmask     (head_tmask),
        .ld_rd        (head_rd),
        .ld_data      (ld_data),
        .st_valid     (exec_fire && (is_store || is_fence)),
        .st_wid       (exec_wid),
        .st_tmask     (exec_tmask),
        .commit_ready (commit_ready),
        .ld_ready     (mem_rsp_ready),
        .st_ready     (st_ready),
        .commit_valid (commit_valid),
        .commit_wid   (commit_wid),
        .commit_tmask (commit_tmask),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

// File: tb/lsu_mem_model.sv
// lsu_mem_model: word memory behind the LSU, returns load data in order after random latency
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_model
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         req_valid,
    input  logic         req_rw,
    input  lane_mask_t   req_mask,
    input  lane_addr_t   req_addr,
    input  lane_byteen_t req_byteen,
    input  lane_data_t   req_data,
    output logic         req_ready,
    output logic         rsp_valid,
    output lane_data_t   rsp_data,
    input  logic         rsp_ready
);

    localparam int mem_words = 256;

    word_t       mem [mem_words];
    lane_data_t  rsp_q [$];
    int unsigned due_q [$];
    int unsigned cycle;

    initial begin
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        for (int w = 0; w < mem_words; w++) begin
            mem[w] = '0;
        end
    end

    always @(posedge clk) begin
        lane_data_t rd_words;
        if (reset) begin
            rsp_q.delete();
            due_q.delete();
            cycle = 0;
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_data  <= '0;
        end else begin
            cycle = cycle + 1;
            if (rsp_valid && rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (req_valid && req_ready) begin
                if (req_rw) begin
                    for (int l = 0; l < num_lanes; l++) begin
                        for (int b = 0; b < word_bytes; b++) begin
                            if (req_mask[l] && req_byteen[l][b]) begin
                                mem[req_addr[l][7:0]][8*b +: 8] = req_data[l][8*b +: 8];
                            end
                        end
                    end
                end else begin
                    // read at acceptance so later stores do not leak in
                    for (int l = 0; l < num_lanes; l++) begin
                        rd_words[l] = mem[req_addr[l][7:0]];
                    end
                    rsp_q.push_back(rd_words);
                    due_q.push_back(cycle + $urandom_range(1, 4));
                end
            end
            // head stays on offer until taken
            if (rsp_q.size() != 0 && due_q[0] <= cycle) begin
                rsp_valid <= 1'b1;
                rsp_data  <= rsp_q[0];
            end else begin
                rsp_valid <= 1'b0;
            end
            req_ready <= ($urandom_range(0, 7) != 0);
        end
    end

endmodule

`default_nettype wire

// File: tb/lsu_tb.sv
// lsu_tb: testbench for the load/store unit, runs file vectors and checks commits in order
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int num_vecs  = 19;
    localparam int vec_words = 18;

    logic         clk;
    logic         reset;
    logic         exec_valid;
    lsu_op_t      exec_op;
    wid_t         exec_wid;
    lane_mask_t   exec_tmask;
    reg_idx_t     exec_rd;
    lane_data_t   exec_rs1;
    lane_data_t   exec_rs2;
    word_t        exec_imm;
    logic         exec_ready;
    logic         mem_req_valid;
    logic         mem_req_rw;
    lane_mask_t   mem_req_mask;
    lane_addr_t   mem_req_addr;
    lane_byteen_t mem_req_byteen;
    lane_data_t   mem_req_data;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    lane_data_t   mem_rsp_data;
    logic         mem_rsp_ready;
    logic         commit_valid;
    wid_t         commit_wid;
    lane_mask_t   commit_tmask;
    reg_idx_t     commit_rd;
    logic         commit_wb;
    lane_data_t   commit_data;
    logic         commit_ready;

    word_t vec_mem [vec_words*num_vecs];

    // expected commits in issue order
    word_t      exp_id    [$];
    lsu_op_t    exp_op    [$];
    wid_t       exp_wid   [$];
    lane_mask_t exp_tmask [$];
    reg_idx_t   exp_rd    [$];
    logic       exp_wb    [$];
    lane_data_t exp_data  [$];

    int tests_passed = 0;
    int tests_failed = 0;
    int errors = 0;

    lsu_unit dut_i (.*);

    lsu_mem_model mem_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (mem_req_valid),
        .req_rw     (mem_req_rw),
        .req_mask   (mem_req_mask),
        .req_addr   (mem_req_addr),
        .req_byteen (mem_req_byteen),
        .req_data   (mem_req_data),
        .req_ready  (mem_req_ready),
        .rsp_valid  (mem_rsp_valid),
        .rsp_data   (mem_rsp_data),
        .rsp_ready  (mem_rsp_ready)
    );

    always #2 clk = ~clk;

    function automatic logic writes_back(lsu_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    endfunction

    task automatic check_data(string name, lane_data_t exp, lane_data_t act, inout bit ok);
        if (act !== exp) begin
            $display("Error %s data: expected %h actual %h", name, exp, act);
            ok = 0;
        end
    endtask

    task automatic check_mask(string name, lane_mask_t exp, lane_mask_t act, inout bit ok);
        if (act !== exp) begin
            $display("Error %s tmask: expected %h actual %h", name, exp, act);
            ok = 0;
        end
    endtask

    task automatic check_rd(string name, reg_idx_t exp, reg_idx_t act, inout bit ok);
        if (act !== exp) begin
            $display("Error %s rd: expected %0d actual %0d", name, exp, act);
            ok = 0;
        end
    endtask

    task automatic check_wid(string name, wid_t exp, wid_t act, inout bit ok);
        if (act !== exp) begin
            $display("Error %s wid: expected %0d actual %0d", name, exp, act);
            ok = 0;
        end
    endtask

    task automatic drop_expected(int k);
        exp_id.delete(k);
        exp_op.delete(k);
        exp_wid.delete(k);
        exp_tmask.delete(k);
        exp_rd.delete(k);
        exp_wb.delete(k);
        exp_data.delete(k);
    endtask

    task automatic issue(int n);
        int         base;
        int         gap;
        lsu_op_t    op;
        lane_data_t rs1;
        lane_data_t rs2;
        lane_data_t expd;
        base = n * vec_words;
        gap  = $urandom_range(0, 2);
        op   = lsu_op_t'(vec_mem[base + 1][3:0]);
        for (int l = 0; l < num_lanes; l++) begin
            rs1[l]  = vec_mem[base + 5 + l];
            rs2[l]  = vec_mem[base + 10 + l];
            expd[l] = vec_mem[base + 14 + l];
        end
        if (gap != 0) begin
            exec_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        exec_valid <= 1'b1;
        exec_op    <= op;
        exec_wid   <= wid_t'(vec_mem[base + 2]);
        exec_tmask <= lane_mask_t'(vec_mem[base + 3]);
        exec_rd    <= reg_idx_t'(vec_mem[base + 4]);
        exec_rs1   <= rs1;
        exec_imm   <= vec_mem[base + 9];
        exec_rs2   <= rs2;
        do begin
            @(posedge clk);
        end while (!exec_ready);
        exp_id.push_back(vec_mem[base]);
        exp_op.push_back(op);
        exp_wid.push_back(wid_t'(vec_mem[base + 2]));
        exp_tmask.push_back(lane_mask_t'(vec_mem[base + 3]));
        exp_rd.push_back(writes_back(op) ? reg_idx_t'(vec_mem[base + 4]) : reg_idx_t'(0));
        exp_wb.push_back(writes_back(op));
        exp_data.push_back(expd);
    endtask

    // loads match loads in order, stores and fences match their own order
    always @(posedge clk) begin
        int    k;
        bit    ok;
        string name;
        if (reset) begin
            commit_ready <= 1'b0;
        end else begin
            if (commit_valid && commit_ready) begin
                k = -1;
                for (int i = 0; i < exp_id.size(); i++) begin
                    if (k < 0 && exp_wb[i] == commit_wb) begin
                        k = i;
                    end
                end
                if (k < 0) begin
                    $display("commit from warp %0d arrived with nothing left to match",
                             commit_wid);
                    errors++;
                end else begin
                    name = $sformatf("t%02h", exp_id[k][7:0]);
                    ok   = 1;
                    if (exp_op[k] == op_fence && k != 0) begin
                        $display("%s: fence committed while an earlier load was pending", name);
                        ok = 0;
                    end
                    check_wid(name, exp_wid[k], commit_wid, ok);
                    check_mask(name, exp_tmask[k], commit_tmask, ok);
                    check_rd(name, exp_rd[k], commit_rd, ok);
                    check_data(name, exp_data[k], commit_data, ok);
                    if (ok) begin
                        $display("%s op %h: pass", name, exp_op[k]);
                        tests_passed++;
                    end else begin
                        $display("%s op %h: fail", name, exp_op[k]);
                        tests_failed++;
                    end
                    drop_expected(k);
                end
            end
            commit_ready <= ($urandom_range(0, 3) != 0);
        end
    end

    initial begin
        repeat (num_vecs * 20 + 100) @(posedge clk);
        $display("timeout after %0d cycles with %0d commits missing",
                 num_vecs * 20 + 100, exp_id.size());
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        exec_valid   = 1'b0;
        exec_op      = op_lw;
        exec_wid     = '0;
        exec_tmask   = '0;
        exec_rd      = '0;
        exec_rs1     = '0;
        exec_rs2     = '0;
        exec_imm     = '0;
        commit_ready = 1'b0;
        void'($urandom(32'hdc385f0a));
        $readmemh("tb/lsu_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        if ($isunknown(vec_mem[vec_words*num_vecs-1])) begin
            $display("vector file tb/lsu_vectors.txt is missing or short");
            errors++;
        end else begin
            for (int n = 0; n < num_vecs; n++) begin
                issue(n);
            end
            exec_valid <= 1'b0;
            while (exp_id.size() != 0) begin
                @(posedge clk);
            end
            // catch repeated commits
            repeat (20) @(posedge clk);
        end
        $display("%0d tests passed, %0d failed, %0d other errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && tests_passed == num_vecs) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/lsu_pkg.sv
rtl/lsu_req_format.sv
rtl/lsu_pending_queue.sv
rtl/lsu_load_format.sv
rtl/lsu_commit_arb.sv
rtl/lsu_unit.sv
tb/lsu_mem_model.sv
tb/lsu_tb.sv

// File: tb/lsu_vectors.txt
// id op wid tmask rd | rs1 lanes 0..3 | imm | rs2 lanes 0..3 | expected commit data lanes 0..3
// op: 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu, 8 sb, 9 sh, a sw, f fence
01 a 1 f 0 100 104 108 10c 0 11223344 55667788 99aabbcc ddeeff00 0 0 0 0
02 2 1 5 3 100 104 108 10c 0 0 0 0 0 11223344 0 99aabbcc 0
03 8 2 f 0 100 105 10a 10f 0 ffffffaa ffffffbb ffffffcc ffffffee 0 0 0 0
04 9 2 b 0 110 112 114 116 0 ffff1234 ffff5678 0000abcd 00009876 0 0 0 0
05 2 2 f 4 100 104 108 10c 0 0 0 0 0 112233aa 5566bb88 99ccbbcc eeeeff00
06 2 2 3 5 110 114 0 0 0 0 0 0 0 56781234 98760000 0 0
07 0 3 f 6 100 101 102 103 0 0 0 0 0 ffffffaa 33 22 11
08 4 3 f 7 10c 10d 10e 10f 0 0 0 0 0 0 ff ee ee
09 1 3 f 8 110 112 114 116 0 0 0 0 0 1234 5678 0 ffff9876
0a 5 3 6 9 100 102 108 10a 0 0 0 0 0 0 1122 bbcc 0
0b 2 4 f a 104 108 10c 110 0 0 0 0 0 5566bb88 99ccbbcc eeeeff00 56781234
0c 2 5 f b 110 114 118 11c fffffff0 0 0 0 0 112233aa 5566bb88 99ccbbcc eeeeff00
0d 2 6 f c f0 f4 f8 fc 20 0 0 0 0 56781234 98760000 0 0
0e 2 7 9 d 10c 100 100 104 4 0 0 0 0 56781234 0 0 99ccbbcc
0f 1 0 f e 104 10a 112 118 fffffffe 0 0 0 0 1122 ffffbbcc 1234 ffff9876
10 2 1 f f 100 100 100 100 8 0 0 0 0 99ccbbcc 99ccbbcc 99ccbbcc 99ccbbcc
11 f 2 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0
12 a 3 f 0 120 124 128 12c 0 a5a5a5a5 5a5a5a5a 01234567 89abcdef 0 0 0 0
13 2 3 f 1f 120 124 128 12c 0 0 0 0 0 a5a5a5a5 5a5a5a5a 01234567 89abcdef
